// File: Makefile
# Verilator flow for the discrete mapper core

TOP = mapper_core_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

# RTL top on its own, then the whole testbench
lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f build.f --top-module mapper_core
	verilator --lint-only --timing --timescale 1ns/100ps -f build.f --top-module $(TOP)

# The log decides pass or fail
sim:
	verilator --binary --timing --timescale 1ns/100ps -f build.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^STATUS: PASS$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
+incdir+include
verilog/mapper_pkg.sv
verilog/mapper_registers.sv
verilog/prg_address_map.sv
verilog/chr_address_map.sv
verilog/mapper_core.sv
tests/mapper_core_tb.sv

// File: include/mapper_settings.svh
// ####################
// Mapper settings
// Bus widths, iNES mapper numbers, NINA-001 register addresses
// ####################

`ifndef MAPPER_SETTINGS_SVH
`define MAPPER_SETTINGS_SVH

`define MAPPER_CPU_ADDR_W 16 // CPU bus
`define MAPPER_PPU_ADDR_W 14 // PPU bus
`define MAPPER_MEM_ADDR_W 22 // External memory
`define MAPPER_DATA_W 8
`define MAPPER_PRG_BANK_W 6 // 32 KB PRG banks
`define MAPPER_CHR_BANK_W 4 // 4 KB or 8 KB CHR banks

`define MAPPER_NUM_NROM 8'd0
`define MAPPER_NUM_CPROM 8'd13
`define MAPPER_NUM_BXROM 8'd34 // Also NINA-001 when CHR size is set
`define MAPPER_NUM_GXROM 8'd66
`define MAPPER_NUM_CAMERICA 8'd71

`define MAPPER_NINA_PRG_REG 16'h7FFD
`define MAPPER_NINA_CHR_LO_REG 16'h7FFE
`define MAPPER_NINA_CHR_HI_REG 16'h7FFF

`endif

// File: tests/mapper_core_tb.sv
// ####################
// Mapper core testbench
// Table of bank writes and address checks for each mapper kind
// ####################

`default_nettype none

`include "mapper_settings.svh"

module mapper_core_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import mapper_pkg::*;

	localparam int CLK_PERIOD = 4; // ns
	localparam int CYCLES_PER_ROW = 8; // Reset, write and check at most

	// Flags and an optional CPU write ahead of one read-check
	typedef struct packed {
		mapper_id_t id;
		chr_size_t size;
		logic vmirror;
		logic cram;
		logic hold; // New flags without a reset
		logic wr_en;
		cpu_addr_t wr_addr;
		data_t wr_data;
		logic rd_write; // prg_write level during the check
		cpu_addr_t prg_base;
		ppu_addr_t chr_base;
		mem_addr_t exp_prg;
		logic exp_allow;
		mem_addr_t exp_chr;
		logic exp_a10;
	} row_t;

	logic clk;
	logic reset;
	logic ce;
	mapper_id_t mapper_id;
	logic vertical_mirroring;
	logic chr_ram;
	chr_size_t chr_size;
	cpu_addr_t prg_ain;
	logic prg_write;
	data_t prg_din;
	ppu_addr_t chr_ain;
	mem_addr_t prg_aout;
	logic prg_allow;
	mem_addr_t chr_aout;
	logic chr_allow;
	logic vram_ce;
	logic vram_a10;

	row_t rows[$];
	string names[$];
	logic table_ready;

	mapper_core u_dut (
		.clk(clk),
		.reset(reset),
		.ce(ce),
		.mapper_id(mapper_id),
		.vertical_mirroring(vertical_mirroring),
		.chr_ram(chr_ram),
		.chr_size(chr_size),
		.prg_ain(prg_ain),
		.prg_write(prg_write),
		.prg_din(prg_din),
		.chr_ain(chr_ain),
		.prg_aout(prg_aout),
		.prg_allow(prg_allow),
		.chr_aout(chr_aout),
		.chr_allow(chr_allow),
		.vram_ce(vram_ce),
		.vram_a10(vram_a10)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic add_row(input string name, input mapper_id_t id, input chr_size_t size,
		input logic vm, input logic cram, input logic hold,
		input logic wr_en, input cpu_addr_t wr_addr, input data_t wr_data,
		input logic rd_write, input cpu_addr_t prg_base, input ppu_addr_t chr_base,
		input mem_addr_t exp_prg, input logic exp_allow, input mem_addr_t exp_chr,
		input logic exp_a10);
		row_t r;
		r = '{id, size, vm, cram, hold, wr_en, wr_addr, wr_data, rd_write,
			prg_base, chr_base, exp_prg, exp_allow, exp_chr, exp_a10};
		rows.push_back(r);
		names.push_back(name);
	endtask

	// Bases leave bits [12:0] of PRG and [9:0] of CHR clear for random fill
	task automatic load_table();
		add_row("nrom_read_low", `MAPPER_NUM_NROM, 3'd0, 1'b1, 1'b0, 1'b0,
			1'b0, 16'h0000, 8'h00,
			1'b0, 16'h8000, 14'h0400, 22'h000000, 1'b1, 22'h200400, 1'b1);
		add_row("nrom_read_high", `MAPPER_NUM_NROM, 3'd0, 1'b1, 1'b0, 1'b0,
			1'b0, 16'h0000, 8'h00,
			1'b0, 16'hE000, 14'h2800, 22'h006000, 1'b1, 22'h200800, 1'b0);
		add_row("nrom_write_blocked", `MAPPER_NUM_NROM, 3'd0, 1'b1, 1'b0, 1'b0,
			1'b0, 16'h0000, 8'h00,
			1'b1, 16'hA000, 14'h0000, 22'h002000, 1'b0, 22'h200000, 1'b0);
		add_row("nrom_below_rom", `MAPPER_NUM_NROM, 3'd0, 1'b1, 1'b0, 1'b0,
			1'b0, 16'h0000, 8'h00,
			1'b0, 16'h6000, 14'h0400, 22'h006000, 1'b0, 22'h200400, 1'b1);
		add_row("nrom_horizontal", `MAPPER_NUM_NROM, 3'd0, 1'b0, 1'b0, 1'b0,
			1'b0, 16'h0000, 8'h00,
			1'b0, 16'h8000, 14'h2800, 22'h000000, 1'b1, 22'h200800, 1'b1);
		add_row("gxrom_reset", `MAPPER_NUM_GXROM, 3'd0, 1'b1, 1'b0, 1'b0,
			1'b0, 16'h0000, 8'h00,
			1'b0, 16'h8000, 14'h0000, 22'h000000, 1'b1, 22'h200000, 1'b0);
		add_row("gxrom_bank_3_3", `MAPPER_NUM_GXROM, 3'd0, 1'b1, 1'b0, 1'b0,
			1'b1, 16'h8000, 8'h33,
			1'b0, 16'hC000, 14'h1000, 22'h01C000, 1'b1, 22'h207000, 1'b0);
		add_row("gxrom_bank_1_2", `MAPPER_NUM_GXROM, 3'd0, 1'b1, 1'b0, 1'b0,
			1'b1, 16'hFFFF, 8'h12,
			1'b0, 16'h8000, 14'h0400, 22'h008000, 1'b1, 22'h204400, 1'b1);
		add_row("cprom_reset", `MAPPER_NUM_CPROM, 3'd0, 1'b1, 1'b1, 1'b0,
			1'b0, 16'h0000, 8'h00,
			1'b0, 16'h8000, 14'h1000, 22'h000000, 1'b1, 22'h100000, 1'b0);
		add_row("cprom_bank_2", `MAPPER_NUM_CPROM, 3'd0, 1'b1, 1'b1, 1'b0,
			1'b1, 16'h8000, 8'hFE,
			1'b0, 16'h9000, 14'h1400, 22'h001000, 1'b1, 22'h102400, 1'b1);
		add_row("cprom_low_fixed", `MAPPER_NUM_CPROM, 3'd0, 1'b1, 1'b1, 1'b0,
			1'b0, 16'h0000, 8'h00,
			1'b0, 16'h8000, 14'h0800, 22'h000000, 1'b1, 22'h100800, 1'b0);
		add_row("bxrom_reset_hi", `MAPPER_NUM_BXROM, 3'd0, 1'b0, 1'b0, 1'b0,
			1'b0, 16'h0000, 8'h00,
			1'b0, 16'h8000, 14'h1000, 22'h000000, 1'b1, 22'h201000, 1'b0);
		add_row("bxrom_reset_lo", `MAPPER_NUM_BXROM, 3'd0, 1'b0, 1'b0, 1'b0,
			1'b0, 16'h0000, 8'h00,
			1'b0, 16'h8000, 14'h0800, 22'h000000, 1'b1, 22'h200800, 1'b1);
		add_row("bxrom_bank_2a", `MAPPER_NUM_BXROM, 3'd0, 1'b0, 1'b0, 1'b0,
			1'b1, 16'h8000, 8'h2A,
			1'b0, 16'hC000, 14'h1000, 22'h154000, 1'b1, 22'h201000, 1'b0);
		add_row("nina_prg_bank", `MAPPER_NUM_BXROM, 3'd1, 1'b1, 1'b0, 1'b0,
			1'b1, `MAPPER_NINA_PRG_REG, 8'h05,
			1'b0, 16'h8000, 14'h0000, 22'h028000, 1'b1, 22'h200000, 1'b0);
		add_row("nina_chr_lo", `MAPPER_NUM_BXROM, 3'd1, 1'b1, 1'b0, 1'b0,
			1'b1, `MAPPER_NINA_CHR_LO_REG, 8'hF7,
			1'b0, 16'h8000, 14'h0400, 22'h028000, 1'b1, 22'h207400, 1'b1);
		add_row("nina_chr_hi", `MAPPER_NUM_BXROM, 3'd1, 1'b1, 1'b0, 1'b0,
			1'b1, `MAPPER_NINA_CHR_HI_REG, 8'h0C,
			1'b0, 16'hC000, 14'h1000, 22'h02C000, 1'b1, 22'h20C000, 1'b0);
		add_row("nina_ram_read", `MAPPER_NUM_BXROM, 3'd1, 1'b1, 1'b0, 1'b0,
			1'b0, 16'h0000, 8'h00,
			1'b0, 16'h6000, 14'h0000, 22'h3C0000, 1'b1, 22'h207000, 1'b0);
		add_row("nina_ram_write", `MAPPER_NUM_BXROM, 3'd1, 1'b1, 1'b0, 1'b0,
			1'b0, 16'h0000, 8'h00,
			1'b1, 16'h7000, 14'h0400, 22'h3C1000, 1'b1, 22'h207400, 1'b1);
		add_row("camerica_upper_fixed", `MAPPER_NUM_CAMERICA, 3'd0, 1'b0, 1'b1, 1'b0,
			1'b0, 16'h0000, 8'h00,
			1'b0, 16'hC000, 14'h0000, 22'h03C000, 1'b1, 22'h200000, 1'b0);
		add_row("camerica_lower_bank", `MAPPER_NUM_CAMERICA, 3'd0, 1'b0, 1'b1, 1'b0,
			1'b1, 16'hC000, 8'h03,
			1'b0, 16'h8000, 14'h0800, 22'h00C000, 1'b1, 22'h200800, 1'b0);
		add_row("camerica_one_screen", `MAPPER_NUM_CAMERICA, 3'd0, 1'b0, 1'b1, 1'b0,
			1'b1, 16'h8000, 8'h10,
			1'b0, 16'hA000, 14'h2000, 22'h00E000, 1'b1, 22'h200000, 1'b1);
		add_row("latch_keeps_camerica", `MAPPER_NUM_NROM, 3'd0, 1'b0, 1'b1, 1'b1,
			1'b0, 16'h0000, 8'h00,
			1'b0, 16'hC000, 14'h0800, 22'h03C000, 1'b1, 22'h200800, 1'b1);
		add_row("unknown_as_nrom", 8'd200, 3'd0, 1'b0, 1'b0, 1'b0,
			1'b1, 16'h8000, 8'hFF,
			1'b0, 16'hC000, 14'h1800, 22'h004000, 1'b1, 22'h201800, 1'b1);
	endtask

	function automatic logic flags_differ(input row_t a, input row_t b);
		return {a.id, a.size, a.vmirror, a.cram} != {b.id, b.size, b.vmirror, b.cram};
	endfunction

	task automatic drive_flags(input row_t r);
		mapper_id = r.id;
		chr_size = r.size;
		vertical_mirroring = r.vmirror;
		chr_ram = r.cram;
	endtask

	task automatic reset_with_flags(input row_t r);
		@(negedge clk);
		drive_flags(r); // Kind is latched from these
		reset = 1'b1;
		ce = 1'b0;
		prg_write = 1'b0;
		repeat (4) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic cpu_write(input cpu_addr_t addr, input data_t data);
		@(negedge clk);
		prg_ain = addr;
		prg_din = data;
		prg_write = 1'b1;
		ce = 1'b1; // Sampled at the next rising edge
		@(negedge clk);
		ce = 1'b0;
		prg_write = 1'b0;
	endtask

	task automatic check_mem_addr(input string test, input string signal,
		input mem_addr_t expected, input mem_addr_t actual);
		if (actual !== expected) begin
			$display("Error: %s %s expected %06h actual %06h", test, signal, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "Address mismatch in %s", test);
		end
	endtask

	task automatic check_bit(input string test, input string signal,
		input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Error: %s %s expected %b actual %b", test, signal, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "Bit mismatch in %s", test);
		end
	endtask

	task automatic read_check(input int idx);
		row_t r;
		logic [31:0] fill;
		cpu_addr_t prg_in;
		ppu_addr_t chr_in;
		mem_addr_t exp_prg;
		mem_addr_t exp_chr;
		r = rows[idx];
		fill = $urandom();
		prg_in = r.prg_base | {3'b000, fill[12:0]}; // Unbanked bits pass straight through
		chr_in = r.chr_base | {4'b0000, fill[25:16]};
		exp_prg = r.exp_prg | {9'd0, fill[12:0]};
		exp_chr = r.exp_chr | {12'd0, fill[25:16]};
		@(negedge clk);
		ce = 1'b0;
		prg_ain = prg_in;
		prg_write = r.rd_write;
		chr_ain = chr_in;
		#1; // Maps are combinational
		check_mem_addr(names[idx], "prg_aout", exp_prg, prg_aout);
		check_bit(names[idx], "prg_allow", r.exp_allow, prg_allow);
		check_mem_addr(names[idx], "chr_aout", exp_chr, chr_aout);
		check_bit(names[idx], "chr_allow", r.cram, chr_allow);
		check_bit(names[idx], "vram_ce", chr_in[13], vram_ce);
		check_bit(names[idx], "vram_a10", r.exp_a10, vram_a10);
	endtask

	// Watchdog
	initial begin
		wait (table_ready === 1'b1);
		#(rows.size() * CYCLES_PER_ROW * CLK_PERIOD + 200);
		$display("Timeout: the test table did not finish within its time budget");
		$display("STATUS: FAIL");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		row_t r;
		clk = 1'b0;
		reset = 1'b1;
		ce = 1'b0;
		mapper_id = '0;
		vertical_mirroring = 1'b0;
		chr_ram = 1'b0;
		chr_size = '0;
		prg_ain = '0;
		prg_write = 1'b0;
		prg_din = '0;
		chr_ain = '0;
		table_ready = 1'b0;
		void'($urandom(32'h016fda78));
		load_table();
		table_ready = 1'b1;
		for (int i = 0; i < rows.size(); i++) begin
			r = rows[i];
			if (r.hold) begin
				@(negedge clk);
				drive_flags(r); // Registers keep the latched kind
			end else if (i == 0) begin
				reset_with_flags(r);
			end else if (flags_differ(r, rows[i - 1])) begin
				reset_with_flags(r);
			end
			if (r.wr_en) begin
				cpu_write(r.wr_addr, r.wr_data);
			end
			read_check(i);
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/chr_address_map.sv
// ####################
// CHR address map
// PPU address to memory address, VRAM select and mirroring A10
// ####################

`default_nettype none

module chr_address_map (
	input mapper_pkg::mapper_kind_t kind,
	input mapper_pkg::chr_bank_t chr_bank_lo,
	input mapper_pkg::chr_bank_t chr_bank_hi,
	input logic ciram_select,
	input mapper_pkg::ppu_addr_t chr_ain,
	input logic vertical_mirroring,
	input logic chr_ram, // Cart has CHR RAM
	output mapper_pkg::mem_addr_t chr_aout,
	output logic chr_allow,
	output logic vram_ce, // Nametable access to internal VRAM
	output logic vram_a10
);

	import mapper_pkg::*;

	chr_bank_t half_bank; // 4 KB bank for the addressed half

	assign half_bank = chr_ain[12] ? chr_bank_hi : chr_bank_lo;

	always_comb begin
		case (kind)
			kind_cprom: begin
				// Lower 4 KB fixed at bank 0
				chr_aout = {8'b01000000, chr_ain[12] ? chr_bank_lo[1:0] : 2'b00, chr_ain[11:0]};
			end
			kind_gxrom: begin
				chr_aout = {2'b10, 3'b000, chr_bank_lo, chr_ain[12:0]}; // 8 KB banks
			end
			kind_bxrom, kind_nina: begin
				chr_aout = {6'b100000, half_bank, chr_ain[11:0]};
			end
			default: begin
				chr_aout = {9'b100000000, chr_ain[12:0]}; // Unbanked NROM and Camerica
			end
		endcase
	end

	assign chr_allow = chr_ram; // Writes only reach RAM
	assign vram_ce = chr_ain[13];

	always_comb begin
		if (vertical_mirroring) begin
			vram_a10 = chr_ain[10];
		end else if (kind == kind_camerica) begin
			vram_a10 = ciram_select; // Software one-screen select
		end else begin
			vram_a10 = chr_ain[11]; // Horizontal
		end
	end

endmodule

`default_nettype wire

// File: verilog/mapper_core.sv
// ####################
// Discrete mapper core
// Bank registers feeding the PRG and CHR address maps
// ####################

`default_nettype none

module mapper_core (
	input logic clk,
	input logic reset,
	input logic ce, // CPU cycle strobe
	input mapper_pkg::mapper_id_t mapper_id, // Cart flags stay stable from reset on
	input logic vertical_mirroring,
	input logic chr_ram,
	input mapper_pkg::chr_size_t chr_size,
	input mapper_pkg::cpu_addr_t prg_ain,
	input logic prg_write,
	input mapper_pkg::data_t prg_din,
	input mapper_pkg::ppu_addr_t chr_ain,
	output mapper_pkg::mem_addr_t prg_aout,
	output logic prg_allow,
	output mapper_pkg::mem_addr_t chr_aout,
	output logic chr_allow,
	output logic vram_ce,
	output logic vram_a10
);

	import mapper_pkg::*;

	mapper_kind_t kind;
	prg_bank_t prg_bank;
	chr_bank_t chr_bank_lo;
	chr_bank_t chr_bank_hi;
	logic ciram_select;

	mapper_registers u_registers (
		.clk(clk),
		.reset(reset),
		.ce(ce),
		.mapper_id(mapper_id),
		.chr_size(chr_size),
		.prg_ain(prg_ain),
		.prg_write(prg_write),
		.prg_din(prg_din),
		.kind(kind),
		.prg_bank(prg_bank),
		.chr_bank_lo(chr_bank_lo),
		.chr_bank_hi(chr_bank_hi),
		.ciram_select(ciram_select)
	);

	// Same-cycle address path
	prg_address_map u_prg_map (
		.kind(kind),
		.prg_bank(prg_bank),
		.prg_ain(prg_ain),
		.prg_write(prg_write),
		.prg_aout(prg_aout),
		.prg_allow(prg_allow)
	);

	chr_address_map u_chr_map (
		.kind(kind),
		.chr_bank_lo(chr_bank_lo),
		.chr_bank_hi(chr_bank_hi),
		.ciram_select(ciram_select),
		.chr_ain(chr_ain),
		.vertical_mirroring(vertical_mirroring),
		.chr_ram(chr_ram),
		.chr_aout(chr_aout),
		.chr_allow(chr_allow),
		.vram_ce(vram_ce),
		.vram_a10(vram_a10)
	);

endmodule

`default_nettype wire

// File: verilog/mapper_pkg.sv
// ####################
// Mapper package
// Address, bank and data types and the mapper kind
// ####################

`default_nettype none

`include "mapper_settings.svh"

package mapper_pkg;

	typedef logic [`MAPPER_CPU_ADDR_W-1:0] cpu_addr_t; // CPU address
	typedef logic [`MAPPER_PPU_ADDR_W-1:0] ppu_addr_t; // PPU address
	typedef logic [`MAPPER_MEM_ADDR_W-1:0] mem_addr_t; // External memory address
	typedef logic [`MAPPER_DATA_W-1:0] data_t; // Bus byte

	typedef logic [7:0] mapper_id_t; // iNES mapper number
	typedef logic [2:0] chr_size_t; // Zero means 8 KB CHR or less

	typedef logic [`MAPPER_PRG_BANK_W-1:0] prg_bank_t;
	typedef logic [`MAPPER_CHR_BANK_W-1:0] chr_bank_t;

	// Supported discrete boards with NROM as the fallback
	typedef enum logic [2:0] {
		kind_nrom,
		kind_cprom,
		kind_bxrom,
		kind_nina,
		kind_gxrom,
		kind_camerica
	} mapper_kind_t;

endpackage

`default_nettype wire

// File: verilog/mapper_registers.sv
// ####################
// Mapper register block
// Latches the mapper kind in reset, decodes CPU writes to banks
// ####################

`default_nettype none

`include "mapper_settings.svh"

module mapper_registers (
	input logic clk,
	input logic reset,
	input logic ce, // CPU cycle strobe
	input mapper_pkg::mapper_id_t mapper_id,
	input mapper_pkg::chr_size_t chr_size,
	input mapper_pkg::cpu_addr_t prg_ain,
	input logic prg_write,
	input mapper_pkg::data_t prg_din,
	output mapper_pkg::mapper_kind_t kind,
	output mapper_pkg::prg_bank_t prg_bank,
	output mapper_pkg::chr_bank_t chr_bank_lo, // 8 KB bank or NINA 0000-0FFF bank
	output mapper_pkg::chr_bank_t chr_bank_hi, // 1000-1FFF on BxROM/NINA
	output logic ciram_select // Camerica one-screen page
);

	import mapper_pkg::*;

	logic cpu_write;
	logic rom_space; // 8000-FFFF

	// Board from the iNES number
	function automatic mapper_kind_t decode_kind(input mapper_id_t id, input chr_size_t size);
		mapper_kind_t k;
		case (id)
			`MAPPER_NUM_NROM: k = kind_nrom;
			`MAPPER_NUM_CPROM: k = kind_cprom;
			`MAPPER_NUM_BXROM: k = (size == '0) ? kind_bxrom : kind_nina; // NINA has CHR ROM
			`MAPPER_NUM_GXROM: k = kind_gxrom;
			`MAPPER_NUM_CAMERICA: k = kind_camerica;
			default: k = kind_nrom; // Unknown boards fall back to NROM
		endcase
		return k;
	endfunction

	assign cpu_write = ce && prg_write; // One write per CPU cycle
	assign rom_space = prg_ain[15];

	always_ff @(posedge clk) begin
		if (reset) begin
			kind <= decode_kind(mapper_id, chr_size); // Fixed until next reset
			prg_bank <= '0;
			chr_bank_lo <= '0;
			chr_bank_hi <= 4'd1; // BxROM sees CHR as one linear 8 KB
			ciram_select <= 1'b0;
		end else if (cpu_write) begin
			case (kind)
				kind_cprom: begin
					if (rom_space) begin
						chr_bank_lo <= {2'b00, prg_din[1:0]}; // Upper 4 KB only
					end
				end
				kind_gxrom: begin
					if (rom_space) begin
						prg_bank <= {4'b0000, prg_din[5:4]};
						chr_bank_lo <= {2'b00, prg_din[1:0]};
					end
				end
				kind_bxrom: begin
					if (rom_space) begin
						prg_bank <= prg_din[5:0]; // Real boards decode only two bits
					end
				end
				kind_nina: begin
					// Registers sit on top of the PRG RAM window
					if (prg_ain == `MAPPER_NINA_PRG_REG) begin
						prg_bank <= prg_din[5:0];
					end else if (prg_ain == `MAPPER_NINA_CHR_LO_REG) begin
						chr_bank_lo <= prg_din[3:0];
					end else if (prg_ain == `MAPPER_NINA_CHR_HI_REG) begin
						chr_bank_hi <= prg_din[3:0];
					end
				end
				kind_camerica: begin
					if (prg_ain[15:13] == 3'b100) begin
						ciram_select <= prg_din[4]; // Fire Hawk mirroring at 8000-9FFF
					end
					if (prg_ain[15:14] == 2'b11) begin
						prg_bank[3:0] <= prg_din[3:0]; // C000-FFFF bank select
					end
				end
				default: begin
					// NROM has no registers
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/prg_address_map.sv
// ####################
// PRG address map
// CPU address to memory address, NINA RAM window, access permission
// ####################

`default_nettype none

module prg_address_map (
	input mapper_pkg::mapper_kind_t kind,
	input mapper_pkg::prg_bank_t prg_bank,
	input mapper_pkg::cpu_addr_t prg_ain,
	input logic prg_write,
	output mapper_pkg::mem_addr_t prg_aout,
	output logic prg_allow // Memory may serve this access
);

	import mapper_pkg::*;

	logic nina_window; // 6000-7FFF on NINA-001
	mem_addr_t rom_addr;
	mem_addr_t ram_addr;

	assign nina_window = (kind == kind_nina) && (prg_ain[15:13] == 3'b011);
	assign ram_addr = {9'b111100000, prg_ain[12:0]}; // 8 KB PRG RAM area

	always_comb begin
		case (kind)
			kind_bxrom, kind_nina: begin
				rom_addr = {1'b0, prg_bank, prg_ain[14:0]}; // 32 KB banks
			end
			kind_gxrom: begin
				rom_addr = {5'b00000, prg_bank[1:0], prg_ain[14:0]};
			end
			kind_camerica: begin
				// 16 KB banks with the upper half on the last bank
				rom_addr = {4'b0000, prg_ain[14] ? 4'hF : prg_bank[3:0], prg_ain[13:0]};
			end
			default: begin
				rom_addr = {7'b0000000, prg_ain[14:0]}; // NROM and CPROM
			end
		endcase
	end

	assign prg_aout = nina_window ? ram_addr : rom_addr;
	assign prg_allow = (prg_ain[15] && !prg_write) || nina_window; // ROM read-only

endmodule

`default_nettype wire
